// ==== common/ita_package.sv ====
// ITA datapath package
// Widths, lane counts and packed data types of the matrix-vector datapath

package ita_package;

  // Output lanes and inner lanes per tile
  localparam int unsigned N = 4;
  localparam int unsigned M = 4;

  // Input/weight, bias and accumulator widths
  localparam int unsigned WI = 8;
  localparam int unsigned WB = 16;
  localparam int unsigned WA = 26;

  typedef logic signed [WI-1:0] ita_data_t;
  typedef logic signed [WB-1:0] ita_bias_elem_t;
  typedef logic signed [WA-1:0] ita_acc_t;

  // One input beat
  typedef ita_data_t [M-1:0] inp_t;

  // One weight tile, lane n holds row n
  typedef inp_t [N-1:0] weight_t;

  typedef ita_bias_elem_t [N-1:0] bias_t;

  // Products and accumulator results
  typedef ita_acc_t [N-1:0] oup_t;

  // Requantized output beat
  typedef logic [N-1:0][WI-1:0] requant_oup_t;

endpackage

// ==== common/ita_ctrl_pkg.sv ====
// ITA control package
// Job control struct, requantization mode and counter type

package ita_ctrl_pkg;

  typedef logic [7:0] counter_t;

  // Saturation range of the requantized output
  typedef enum logic {
    Signed   = 1'b0,
    Unsigned = 1'b1
  } requant_mode_e;

  typedef struct packed {
    counter_t          rows;
    counter_t          inner_tiles;  // at least 1
    logic        [7:0] eps_mult;
    logic        [4:0] right_shift;
    logic signed [7:0] add;
    requant_mode_e     mode;
  } ctrl_t;

endpackage

// ==== src/fifo_v3.sv ====
// Synchronous FIFO
// Circular buffer with registered head output, full, empty and usage flags
`timescale 1ns/1ps

module fifo_v3 #(
  parameter int unsigned DEPTH      = 4,
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         push_i,
  input  logic                         pop_i,
  input  logic [DATA_WIDTH-1:0]        data_i,
  output logic                         full_o,
  output logic                         empty_o,
  output logic [$clog2(DEPTH+1)-1:0]   usage_o,
  output logic [DATA_WIDTH-1:0]        data_o
);

  localparam int unsigned PtrW = $clog2(DEPTH);
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem_q [DEPTH];
  logic [PtrW-1:0]       wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]       count_q;
  logic                  do_push, do_pop;

  assign full_o  = (count_q == CntW'(DEPTH));
  assign empty_o = (count_q == '0);
  assign usage_o = count_q;
  assign data_o  = mem_q[rd_ptr_q];

  // Pushes into a full and pops from an empty FIFO are ignored
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== src/ita_sumdotp.sv ====
// ITA dot product
// Registered N-lane signed dot product of an input beat with a weight tile
`timescale 1ns/1ps

module ita_sumdotp
  import ita_package::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    calc_en_i,
  input  inp_t    inp_i,
  input  weight_t weight_i,
  output oup_t    oup_o
);

  oup_t dotp;

  always_comb begin
    dotp = '0;
    for (int n = 0; n < N; n++) begin
      for (int m = 0; m < M; m++) begin
        dotp[n] = dotp[n] + inp_i[m] * weight_i[n][m];
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      oup_o <= '0;
    end else if (calc_en_i) begin
      oup_o <= dotp;
    end
  end

endmodule

// ==== src/ita_accumulator.sv ====
// ITA accumulator
// Sums lane products over the inner tiles of a row, starting from the bias
`timescale 1ns/1ps

module ita_accumulator
  import ita_package::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  calc_en_i,
  input  logic  first_tile_i,
  input  oup_t  oup_i,
  input  bias_t bias_i,
  output oup_t  result_o
);

  oup_t acc_q, acc_d;
  oup_t bias_ext;

  always_comb begin
    for (int n = 0; n < N; n++) begin
      bias_ext[n] = {{(WA - WB){bias_i[n][WB-1]}}, bias_i[n]};
    end
  end

  always_comb begin
    for (int n = 0; n < N; n++) begin
      // First tile restarts the sum
      if (first_tile_i) begin
        acc_d[n] = oup_i[n] + bias_ext[n];
      end else begin
        acc_d[n] = acc_q[n] + oup_i[n];
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (calc_en_i) begin
      acc_q <= acc_d;
    end
  end

  assign result_o = acc_q;

endmodule

// ==== src/ita_requantizer.sv ====
// ITA requantizer
// Scales accumulator lanes by multiply, arithmetic shift and add, then saturates to 8 bits
`timescale 1ns/1ps

module ita_requantizer
  import ita_package::*;
  import ita_ctrl_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              calc_en_i,
  input  requant_mode_e     mode_i,
  input  logic        [7:0] eps_mult_i,
  input  logic        [4:0] right_shift_i,
  input  logic signed [7:0] add_i,
  input  oup_t              result_i,
  output requant_oup_t      requant_oup_o
);

  function automatic logic [WI-1:0] requant_lane(ita_acc_t val);
    logic signed [WA+8:0] scaled;
    logic signed [WA+9:0] sum;
    scaled = val * $signed({1'b0, eps_mult_i});
    // Arithmetic shift floors toward minus infinity
    scaled = scaled >>> right_shift_i;
    sum    = scaled + add_i;
    if (mode_i == Signed) begin
      if (sum > 127) begin
        return 8'h7f;
      end else if (sum < -128) begin
        return 8'h80;
      end
    end else begin
      if (sum > 255) begin
        return 8'hff;
      end else if (sum < 0) begin
        return 8'h00;
      end
    end
    return sum[WI-1:0];
  endfunction

  requant_oup_t requant_d;

  always_comb begin
    for (int n = 0; n < N; n++) begin
      requant_d[n] = requant_lane(result_i[n]);
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      requant_oup_o <= '0;
    end else if (calc_en_i) begin
      requant_oup_o <= requant_d;
    end
  end

endmodule

// ==== src/ita_weight_controller.sv ====
// ITA weight buffer
// Two-entry ping-pong store for weight tiles between the weight port and the datapath
`timescale 1ns/1ps

module ita_weight_controller
  import ita_package::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    inp_weight_valid_i,
  input  weight_t inp_weight_i,
  input  logic    weight_ready_i,
  output logic    inp_weight_ready_o,
  output logic    weight_valid_o,
  output weight_t weight_o
);

  weight_t    buf_q [2];
  logic       wr_ptr_q, rd_ptr_q;
  logic [1:0] count_q, count_d;
  logic       wr_en, rd_en;
  logic       ready_q;

  assign wr_en = inp_weight_valid_i && ready_q;
  assign rd_en = weight_ready_i && weight_valid_o;

  assign inp_weight_ready_o = ready_q;
  assign weight_valid_o     = (count_q != 2'd0);
  assign weight_o           = buf_q[rd_ptr_q];

  always_comb begin
    count_d = count_q;
    if (wr_en) begin
      count_d = count_d + 2'd1;
    end
    if (rd_en) begin
      count_d = count_d - 2'd1;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
      ready_q  <= 1'b0;
    end else begin
      count_q <= count_d;
      // Room for another tile while fewer than two are held
      ready_q <= (count_d < 2'd2);
      if (wr_en) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (rd_en) begin
        rd_ptr_q <= !rd_ptr_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      buf_q[wr_ptr_q] <= inp_weight_i;
    end
  end

endmodule

// ==== controller/ita_controller.sv ====
// ITA controller
// Tile and row sequencing, issue handshakes and output FIFO credit tracking
`timescale 1ns/1ps

module ita_controller
  import ita_ctrl_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  ctrl_t ctrl_i,
  input  logic  inp_valid_i,
  input  logic  weight_valid_i,
  input  logic  bias_valid_i,
  input  logic  push_i,
  input  logic  pop_i,
  output logic  inp_ready_o,
  output logic  weight_ready_o,
  output logic  bias_ready_o,
  output logic  calc_en_o,
  output logic  first_tile_o,
  output logic  last_tile_o,
  output logic  busy_o
);

  localparam int unsigned CreditW = $clog2(FIFO_DEPTH + 1);

  counter_t           tile_q, row_q;
  logic               first_tile, last_tile, last_row;
  logic               take_credit;
  logic               issued_all_q, busy_q;
  logic [CreditW-1:0] credit_q, credit_d;
  logic [CreditW-1:0] inflight_q, inflight_d;

  assign first_tile = (tile_q == '0);
  assign last_tile  = (tile_q == counter_t'(ctrl_i.inner_tiles - 8'd1));
  assign last_row   = (row_q == counter_t'(ctrl_i.rows - 8'd1));

  // All channels needed by this tile must be present together
  assign calc_en_o = !issued_all_q && inp_valid_i && weight_valid_i &&
                     (!first_tile || bias_valid_i) &&
                     (!last_tile || (credit_q != '0));

  assign inp_ready_o    = calc_en_o;
  assign weight_ready_o = calc_en_o;
  assign bias_ready_o   = calc_en_o && first_tile;
  assign first_tile_o   = first_tile;
  assign last_tile_o    = last_tile;
  assign busy_o         = busy_q;

  assign take_credit = calc_en_o && last_tile;

  always_comb begin
    credit_d   = credit_q;
    inflight_d = inflight_q;
    if (take_credit) begin
      credit_d   = credit_d - 1'b1;
      inflight_d = inflight_d + 1'b1;
    end
    if (pop_i) begin
      credit_d = credit_d + 1'b1;
    end
    // Result has left the pipeline and sits in the FIFO
    if (push_i) begin
      inflight_d = inflight_d - 1'b1;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      tile_q       <= '0;
      row_q        <= '0;
      issued_all_q <= 1'b0;
      busy_q       <= 1'b0;
      credit_q     <= CreditW'(FIFO_DEPTH);
      inflight_q   <= '0;
    end else begin
      credit_q   <= credit_d;
      inflight_q <= inflight_d;
      if (calc_en_o) begin
        busy_q <= 1'b1;
        if (last_tile) begin
          tile_q <= '0;
          if (last_row) begin
            row_q        <= '0;
            issued_all_q <= 1'b1;
          end else begin
            row_q <= row_q + 8'd1;
          end
        end else begin
          tile_q <= tile_q + 8'd1;
        end
      end else if (issued_all_q && (inflight_d == '0) &&
                   (credit_d == CreditW'(FIFO_DEPTH))) begin
        // Last result popped, ready for the next job
        busy_q       <= 1'b0;
        issued_all_q <= 1'b0;
      end
    end
  end

endmodule

// ==== src/ita.sv ====
// ITA top level
// Tiled matrix-vector engine with dot product, accumulation, requantization and output FIFO
`timescale 1ns/1ps

module ita
  import ita_package::*;
  import ita_ctrl_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  ctrl_t        ctrl_i,
  // Input beats
  input  logic         inp_valid_i,
  output logic         inp_ready_o,
  input  inp_t         inp_i,
  // Weight tiles
  input  logic         inp_weight_valid_i,
  output logic         inp_weight_ready_o,
  input  weight_t      inp_weight_i,
  // Bias beats
  input  logic         inp_bias_valid_i,
  output logic         inp_bias_ready_o,
  input  bias_t        inp_bias_i,
  // Output beats
  output logic         valid_o,
  input  logic         ready_i,
  output requant_oup_t oup_o,
  output logic         busy_o
);

  logic         weight_valid, weight_ready;
  weight_t      weight;
  logic         calc_en, first_tile, last_tile;
  logic         calc_en_q1, calc_en_q2, calc_en_q3;
  logic         first_tile_q1;
  logic         last_tile_q1, last_tile_q2, last_tile_q3;
  bias_t        bias_q1;
  oup_t         dotp_oup, acc_oup;
  requant_oup_t requant_oup, fifo_oup;
  logic         fifo_empty, push, pop;

  // Tile flags follow the issue through the pipeline
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      calc_en_q1    <= 1'b0;
      calc_en_q2    <= 1'b0;
      calc_en_q3    <= 1'b0;
      first_tile_q1 <= 1'b0;
      last_tile_q1  <= 1'b0;
      last_tile_q2  <= 1'b0;
      last_tile_q3  <= 1'b0;
    end else begin
      calc_en_q1    <= calc_en;
      calc_en_q2    <= calc_en_q1;
      calc_en_q3    <= calc_en_q2;
      first_tile_q1 <= first_tile;
      last_tile_q1  <= last_tile;
      last_tile_q2  <= last_tile_q1;
      last_tile_q3  <= last_tile_q2;
    end
  end

  // Bias lines up with the products one cycle later
  always_ff @(posedge clk_i) begin
    if (calc_en && first_tile) begin
      bias_q1 <= inp_bias_i;
    end
  end

  assign push    = calc_en_q3 && last_tile_q3;
  assign valid_o = !fifo_empty;
  assign pop     = valid_o && ready_i;
  assign oup_o   = valid_o ? fifo_oup : '0;

  ita_controller #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_controller (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ctrl_i        (ctrl_i),
    .inp_valid_i   (inp_valid_i),
    .weight_valid_i(weight_valid),
    .bias_valid_i  (inp_bias_valid_i),
    .push_i        (push),
    .pop_i         (pop),
    .inp_ready_o   (inp_ready_o),
    .weight_ready_o(weight_ready),
    .bias_ready_o  (inp_bias_ready_o),
    .calc_en_o     (calc_en),
    .first_tile_o  (first_tile),
    .last_tile_o   (last_tile),
    .busy_o        (busy_o)
  );

  ita_weight_controller i_weight_controller (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .inp_weight_valid_i(inp_weight_valid_i),
    .inp_weight_i      (inp_weight_i),
    .weight_ready_i    (weight_ready),
    .inp_weight_ready_o(inp_weight_ready_o),
    .weight_valid_o    (weight_valid),
    .weight_o          (weight)
  );

  ita_sumdotp i_sumdotp (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .calc_en_i(calc_en),
    .inp_i    (inp_i),
    .weight_i (weight),
    .oup_o    (dotp_oup)
  );

  ita_accumulator i_accumulator (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .calc_en_i   (calc_en_q1),
    .first_tile_i(first_tile_q1),
    .oup_i       (dotp_oup),
    .bias_i      (bias_q1),
    .result_o    (acc_oup)
  );

  ita_requantizer i_requantizer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .calc_en_i    (calc_en_q2 && last_tile_q2),
    .mode_i       (ctrl_i.mode),
    .eps_mult_i   (ctrl_i.eps_mult),
    .right_shift_i(ctrl_i.right_shift),
    .add_i        (ctrl_i.add),
    .result_i     (acc_oup),
    .requant_oup_o(requant_oup)
  );

  // Credits in the controller keep the FIFO from overflowing
  fifo_v3 #(
    .DEPTH     (FIFO_DEPTH),
    .DATA_WIDTH(N * WI)
  ) i_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (push),
    .pop_i  (pop),
    .data_i (requant_oup),
    .full_o (),
    .empty_o(fifo_empty),
    .usage_o(),
    .data_o (fifo_oup)
  );

endmodule

// ==== test/tb_ita.sv ====
// ITA testbench
// Directed tests against a reference model of the tiled matrix-vector engine
`timescale 1ns/1ps

module tb_ita
  import ita_package::*;
  import ita_ctrl_pkg::*;
();

  localparam int FIFO_DEPTH = 4;
  localparam int TIMEOUT    = 2000;

  logic         clk_i;
  logic         rst_ni;
  ctrl_t        ctrl_i;
  logic         inp_valid_i, inp_ready_o;
  inp_t         inp_i;
  logic         inp_weight_valid_i, inp_weight_ready_o;
  weight_t      inp_weight_i;
  logic         inp_bias_valid_i, inp_bias_ready_o;
  bias_t        inp_bias_i;
  logic         valid_o, ready_i;
  requant_oup_t oup_o;
  logic         busy_o;

  int seed = 79140;
  int errors = 0;

  // Current job and collected results
  inp_t         job_inp[$];
  weight_t      job_w[$];
  bias_t        job_bias[$];
  requant_oup_t got_q[$];
  int           inp_accepted;
  int           popped;
  logic         busy_seen;

  ita #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ctrl_i            (ctrl_i),
    .inp_valid_i       (inp_valid_i),
    .inp_ready_o       (inp_ready_o),
    .inp_i             (inp_i),
    .inp_weight_valid_i(inp_weight_valid_i),
    .inp_weight_ready_o(inp_weight_ready_o),
    .inp_weight_i      (inp_weight_i),
    .inp_bias_valid_i  (inp_bias_valid_i),
    .inp_bias_ready_o  (inp_bias_ready_o),
    .inp_bias_i        (inp_bias_i),
    .valid_o           (valid_o),
    .ready_i           (ready_i),
    .oup_o             (oup_o),
    .busy_o            (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic finish_run();
    $display("tb_ita: %0d errors", errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    errors++;
    $display("Timeout at %0t while waiting for %s", $time, what);
    finish_run();
  endtask

  task automatic check_oup(input string name, input requant_oup_t got, input requant_oup_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Expected output beat of one row after accumulate, scale, floor shift, add and saturate
  function automatic requant_oup_t ref_row(input ctrl_t c, input int row);
    requant_oup_t res;
    longint       acc;
    longint       val;
    int           k;
    for (int n = 0; n < N; n++) begin
      acc = longint'(job_bias[row][n]);
      for (int t = 0; t < int'(c.inner_tiles); t++) begin
        k = row * int'(c.inner_tiles) + t;
        for (int m = 0; m < M; m++) begin
          acc += longint'(job_inp[k][m]) * longint'(job_w[k][n][m]);
        end
      end
      val = (acc * longint'(c.eps_mult)) >>> c.right_shift;
      val = val + longint'(c.add);
      if (c.mode == Signed) begin
        val = (val > 127) ? 127 : ((val < -128) ? -128 : val);
      end else begin
        val = (val > 255) ? 255 : ((val < 0) ? 0 : val);
      end
      res[n] = 8'(val);
    end
    return res;
  endfunction

  function automatic int pick_gap(input int gap_max);
    if (gap_max == 0) begin
      return 0;
    end
    return int'({$random(seed)} % (gap_max + 1));
  endfunction

  task automatic clear_job();
    job_inp.delete();
    job_w.delete();
    job_bias.delete();
  endtask

  task automatic random_job(input ctrl_t c);
    inp_t    x;
    weight_t w;
    bias_t   b;
    clear_job();
    for (int k = 0; k < int'(c.rows) * int'(c.inner_tiles); k++) begin
      for (int m = 0; m < M; m++) begin
        x[m] = 8'($random(seed));
        for (int n = 0; n < N; n++) begin
          w[n][m] = 8'($random(seed));
        end
      end
      job_inp.push_back(x);
      job_w.push_back(w);
    end
    for (int r = 0; r < int'(c.rows); r++) begin
      for (int n = 0; n < N; n++) begin
        b[n] = 16'($random(seed) % 4096);
      end
      job_bias.push_back(b);
    end
  endtask

  // Drivers sample ready just after the falling edge, where it is stable
  task automatic drive_inp(input int gap_max);
    bit hs;
    int waited;
    for (int k = 0; k < job_inp.size(); k++) begin
      repeat (pick_gap(gap_max)) @(negedge clk_i);
      inp_valid_i = 1'b1;
      inp_i       = job_inp[k];
      hs          = 1'b0;
      waited      = 0;
      while (!hs) begin
        #1;
        hs = inp_ready_o;
        if (hs) begin
          inp_accepted++;
        end
        @(negedge clk_i);
        waited++;
        if (!hs && waited > TIMEOUT) begin
          timeout_fail("input handshake");
        end
      end
      inp_valid_i = 1'b0;
      inp_i       = '0;
    end
  endtask

  task automatic drive_weight(input int gap_max);
    bit hs;
    int waited;
    for (int k = 0; k < job_w.size(); k++) begin
      repeat (pick_gap(gap_max)) @(negedge clk_i);
      inp_weight_valid_i = 1'b1;
      inp_weight_i       = job_w[k];
      hs                 = 1'b0;
      waited             = 0;
      while (!hs) begin
        #1;
        hs = inp_weight_ready_o;
        @(negedge clk_i);
        waited++;
        if (!hs && waited > TIMEOUT) begin
          timeout_fail("weight handshake");
        end
      end
      inp_weight_valid_i = 1'b0;
      inp_weight_i       = '0;
    end
  endtask

  task automatic drive_bias(input int gap_max);
    bit hs;
    int waited;
    for (int r = 0; r < job_bias.size(); r++) begin
      repeat (pick_gap(gap_max)) @(negedge clk_i);
      inp_bias_valid_i = 1'b1;
      inp_bias_i       = job_bias[r];
      hs               = 1'b0;
      waited           = 0;
      while (!hs) begin
        #1;
        hs = inp_bias_ready_o;
        @(negedge clk_i);
        waited++;
        if (!hs && waited > TIMEOUT) begin
          timeout_fail("bias handshake");
        end
      end
      inp_bias_valid_i = 1'b0;
      inp_bias_i       = '0;
    end
  endtask

  // Pops results with ready held low for the first hold_low cycles
  task automatic collect(input int n_rows, input int tiles, input int hold_low,
                         input bit rand_ready);
    int cyc;
    int idle;
    int pending;
    cyc  = 0;
    idle = 0;
    while (got_q.size() < n_rows) begin
      ready_i = (cyc >= hold_low) && (!rand_ready || ({$random(seed)} % 4 != 0));
      #1;
      if (busy_o) begin
        busy_seen = 1'b1;
      end
      if (valid_o && ready_i) begin
        // Busy stays high until the last result has been popped
        check_bit("busy_o at pop", busy_o, 1'b1);
        got_q.push_back(oup_o);
        popped++;
        idle = 0;
      end else begin
        idle++;
      end
      if (!valid_o) begin
        check_oup("oup_o while idle", oup_o, '0);
      end
      #1;
      pending = inp_accepted / tiles - popped;
      if (!ready_i && pending > FIFO_DEPTH) begin
        errors++;
        $display("%0d results pending at %0t, more than the FIFO holds", pending, $time);
      end
      @(negedge clk_i);
      cyc++;
      if (idle > TIMEOUT) begin
        timeout_fail("an output beat");
      end
    end
    ready_i = 1'b0;
  endtask

  task automatic wait_busy_low();
    int waited;
    waited = 0;
    while (busy_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) begin
        timeout_fail("busy_o to fall");
      end
    end
  endtask

  task automatic run_job(input ctrl_t c, input int inp_gap, input int w_gap, input int b_gap,
                         input int hold_low, input bit rand_ready);
    @(negedge clk_i);
    ctrl_i       = c;
    inp_accepted = 0;
    popped       = 0;
    busy_seen    = 1'b0;
    got_q.delete();
    fork
      drive_inp(inp_gap);
      drive_weight(w_gap);
      drive_bias(b_gap);
      collect(int'(c.rows), int'(c.inner_tiles), hold_low, rand_ready);
    join
    wait_busy_low();
    check_bit("valid_o", valid_o, 1'b0);
    for (int r = 0; r < got_q.size(); r++) begin
      check_oup($sformatf("oup_o row %0d", r), got_q[r], ref_row(c, r));
    end
  endtask

  task automatic test_reset();
    #1;
    check_bit("valid_o", valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("inp_ready_o", inp_ready_o, 1'b0);
    check_bit("inp_weight_ready_o", inp_weight_ready_o, 1'b0);
    check_bit("inp_bias_ready_o", inp_bias_ready_o, 1'b0);
    check_oup("oup_o", oup_o, '0);
  endtask

  task automatic test_single_row();
    ctrl_t   c;
    inp_t    x;
    weight_t w;
    bias_t   b;
    c = '{rows: 8'd1, inner_tiles: 8'd1, eps_mult: 8'd1, right_shift: 5'd1,
          add: -8'sd3, mode: Signed};
    clear_job();
    for (int m = 0; m < M; m++) begin
      x[m] = 8'(m + 1);
      for (int n = 0; n < N; n++) begin
        w[n][m] = (n == m) ? 8'sd2 : -8'sd1;
      end
    end
    b[0] = 16'sd100;
    b[1] = -16'sd50;
    b[2] = 16'sd0;
    b[3] = 16'sd10;
    job_inp.push_back(x);
    job_w.push_back(w);
    job_bias.push_back(b);
    run_job(c, 0, 0, 0, 0, 1'b0);
    check_bit("busy_o during job", busy_seen, 1'b1);
    check_oup("oup_o hand value", got_q[0], {8'h03, 8'hfc, 8'he2, 8'h2b});
  endtask

  task automatic test_saturation(input requant_mode_e mode, input requant_oup_t exp);
    ctrl_t   c;
    inp_t    x;
    weight_t w;
    bias_t   b;
    c = '{rows: 8'd1, inner_tiles: 8'd1, eps_mult: 8'd1, right_shift: 5'd0,
          add: 8'sd0, mode: mode};
    clear_job();
    for (int m = 0; m < M; m++) begin
      x[m]    = 8'sd127;
      w[0][m] = 8'sd127;
      w[1][m] = -8'sd128;
      w[2][m] = 8'sd0;
      w[3][m] = 8'sd0;
    end
    b[0] = 16'sd0;
    b[1] = 16'sd0;
    b[2] = 16'sd32767;
    b[3] = -16'sd32768;
    job_inp.push_back(x);
    job_w.push_back(w);
    job_bias.push_back(b);
    run_job(c, 0, 0, 0, 0, 1'b0);
    check_oup("oup_o saturated", got_q[0], exp);
  endtask

  function automatic ctrl_t random_ctrl(input int rows, input int tiles);
    ctrl_t c;
    c.rows        = 8'(rows);
    c.inner_tiles = 8'(tiles);
    c.eps_mult    = 8'({$random(seed)} % 255 + 1);
    c.right_shift = 5'({$random(seed)} % 6 + 10);
    c.add         = 8'($random(seed));
    c.mode        = requant_mode_e'($random(seed) & 1);
    return c;
  endfunction

  initial begin
    ctrl_t c;
    ctrl_i             = '0;
    inp_valid_i        = 1'b0;
    inp_i              = '0;
    inp_weight_valid_i = 1'b0;
    inp_weight_i       = '0;
    inp_bias_valid_i   = 1'b0;
    inp_bias_i         = '0;
    ready_i            = 1'b0;
    rst_ni             = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    test_reset();
    test_single_row();

    // Weights offered back to back fill both buffer entries
    c = random_ctrl(3, 4);
    random_job(c);
    run_job(c, 2, 0, 2, 0, 1'b0);

    test_saturation(Signed, {8'h80, 8'h7f, 8'h80, 8'h7f});
    test_saturation(Unsigned, {8'h00, 8'hff, 8'h00, 8'hff});

    // Long back-pressure stretch
    c = random_ctrl(12, 2);
    random_job(c);
    run_job(c, 0, 0, 0, 80, 1'b0);

    c = random_ctrl(5, 3);
    random_job(c);
    run_job(c, 6, 6, 6, 0, 1'b1);

    finish_run();
  end

endmodule

// ==== ita.f ====
common/ita_package.sv
common/ita_ctrl_pkg.sv
src/fifo_v3.sv
src/ita_sumdotp.sv
src/ita_accumulator.sv
src/ita_requantizer.sv
src/ita_weight_controller.sv
controller/ita_controller.sv
src/ita.sv
test/tb_ita.sv

// ==== Makefile ====
SIM  := obj_dir/Vtb_ita
SRCS := $(shell grep -v '^+' ita.f)

.PHONY: all run clean

all: run

$(SIM): ita.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_ita -f ita.f

run: $(SIM)
	./$(SIM) | awk '{ print } /\*\*\* PASSED \*\*\*/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
